/* Makefile */
TOP := tb_data_memory_manager

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* data_memory_manager.sv */
module data_memory_manager
  import mem_map_pkg::*;
  import periph_pkg::*;
#(
  parameter int DATA_W    = 32,
  parameter int NUM_BANKS = 4,
  parameter int BANK_AW   = 10
) (
  input  logic              CLK,
  input  logic              rst_n_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic              wren_i,
  input  logic              button_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic [LED_W-1:0]  leds_o
);

  // address port seen through the map
  mem_addr_u addr_w;

  assign addr_w = addr_i;

  // one bus per responder, both fed from the ports
  mem_bus_if #(.DATA_W(DATA_W)) ram_bus ();
  mem_bus_if #(.DATA_W(DATA_W)) io_bus ();

  assign ram_bus.addr  = addr_w;
  assign ram_bus.wdata = wdata_i;
  assign ram_bus.wren  = wren_i;

  assign io_bus.addr  = addr_w;
  assign io_bus.wdata = wdata_i;
  assign io_bus.wren  = wren_i;

  // image banks, regions 0..3
  image_ram_array #(
    .DATA_W    (DATA_W),
    .NUM_BANKS (NUM_BANKS),
    .BANK_AW   (BANK_AW)
  ) ram_array_i (
    .CLK (CLK),
    .bus (ram_bus)
  );

  // led register and button, region 7
  led_button_io #(
    .DATA_W (DATA_W)
  ) io_i (
    .CLK      (CLK),
    .rst_n_i  (rst_n_i),
    .bus      (io_bus),
    .button_i (button_i),
    .leds_o   (leds_o)
  );

  // read word from the region of the previous access
  read_data_mux #(
    .DATA_W (DATA_W)
  ) rd_mux_i (
    .CLK      (CLK),
    .rst_n_i  (rst_n_i),
    .region_i (addr_w.ram_view.region),
    .ram_bus  (ram_bus),
    .io_bus   (io_bus),
    .rdata_o  (rdata_o)
  );

endmodule

/* filelist.f */
mem_map_pkg.sv
periph_pkg.sv
mem_bus_if.sv
image_ram.sv
image_ram_array.sv
led_button_io.sv
read_data_mux.sv
data_memory_manager.sv
tb_data_memory_manager.sv

/* image_ram.sv */
module image_ram #(
  parameter int DATA_W  = 32,
  parameter int BANK_AW = 10
) (
  input  logic               CLK,
  input  logic [BANK_AW-1:0] addr_i,
  input  logic [DATA_W-1:0]  wdata_i,
  input  logic               wren_i,
  output logic [DATA_W-1:0]  rdata_o
);

  localparam int DEPTH = 2 ** BANK_AW;

  // bank storage, contents undefined after reset
  logic [DATA_W-1:0] mem_q [DEPTH];

  // write on the rising edge
  always_ff @(posedge CLK) begin
    if (wren_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // registered read port
  // write-first, a write cycle returns the new word
  always_ff @(posedge CLK) begin
    if (wren_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

/* image_ram_array.sv */
module image_ram_array
  import mem_map_pkg::*;
#(
  parameter int DATA_W    = 32,
  parameter int NUM_BANKS = 4,
  parameter int BANK_AW   = 10
) (
  input logic                CLK,
  mem_bus_if.responder       bus
);

  // per-bank write strobes
  logic [NUM_BANKS-1:0] bank_we;
  // registered read word of each bank
  logic [DATA_W-1:0]    bank_rdata [NUM_BANKS];
  // region of the access being read out
  region_e              region_q;
  // word index inside a bank
  logic [BANK_AW-1:0]   bank_addr;

  // offset bits above the bank depth alias back onto the bank
  assign bank_addr = bus.addr.ram_view.offset[BANK_AW-1:0];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    // only the bank named by the region sees the strobe
    assign bank_we[b] = bus.wren && (bus.addr.ram_view.region == region_e'(b));

    image_ram #(
      .DATA_W  (DATA_W),
      .BANK_AW (BANK_AW)
    ) ram_i (
      .CLK     (CLK),
      .addr_i  (bank_addr),
      .wdata_i (bus.wdata),
      .wren_i  (bank_we[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  // lines up with the bank read registers
  always_ff @(posedge CLK) begin
    region_q <= bus.addr.ram_view.region;
  end

  // pick the addressed bank, zero above the bank range
  always_comb begin
    bus.rdata = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (region_q == region_e'(b)) begin
        bus.rdata = bank_rdata[b];
      end
    end
  end

  // the region decode never strobes two banks together
  a_one_bank_we : assert property (@(posedge CLK) $onehot0(bank_we))
    else $error("image_ram_array: more than one bank write strobe");

endmodule

/* led_button_io.sv */
module led_button_io
  import mem_map_pkg::*;
  import periph_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic             CLK,
  input  logic             rst_n_i,
  mem_bus_if.responder     bus,
  input  logic             button_i,
  output logic [LED_W-1:0] leds_o
);

  // button synchronizer chain, msb is the settled bit
  logic [SYNC_STAGES-1:0] btn_sync_q;
  // write strobe for the led register
  logic                   led_we;
  // register index of the current access
  logic [OFFSET_W-1:0]    reg_idx;

  assign reg_idx = bus.addr.io_view.reg_idx;

  // only region 7, index 0 loads the leds
  // writes to the button index fall through
  assign led_we = bus.wren && (bus.addr.io_view.region == IO) && (reg_idx == REG_LED);

  always_ff @(posedge CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      leds_o     <= '0;
      btn_sync_q <= '0;
    end else begin
      if (led_we) begin
        leds_o <= bus.wdata[LED_W-1:0];
      end
      // shift the raw button in at the bottom
      btn_sync_q <= {btn_sync_q[SYNC_STAGES-2:0], button_i};
    end
  end

  // registered read word
  // led read sees the value from before a same-cycle write
  always_ff @(posedge CLK) begin
    if (reg_idx == REG_LED) begin
      bus.rdata <= {{(DATA_W - LED_W){1'b0}}, leds_o};
    end else if (reg_idx == REG_BUTTON) begin
      bus.rdata <= {{(DATA_W - 1){1'b0}}, btn_sync_q[SYNC_STAGES-1]};
    end else begin
      bus.rdata <= '0;
    end
  end

  // leds only move one edge after a decoded led write
  a_led_needs_write : assert property (
    @(posedge CLK) disable iff (!rst_n_i)
    !$stable(leds_o) |-> $past(led_we)
  ) else $error("led_button_io: leds changed without a led write");

  // leds come out of reset dark
  a_led_reset : assert property (
    @(posedge CLK) $rose(rst_n_i) |-> (leds_o == '0)
  ) else $error("led_button_io: leds not cleared by reset");

endmodule

/* mem_bus_if.sv */
interface mem_bus_if
  import mem_map_pkg::*;
#(
  parameter int DATA_W = 32
);

  // request side, shared by all responders
  mem_addr_u         addr;
  logic [DATA_W-1:0] wdata;
  // one-cycle write strobe
  logic              wren;

  // registered read word, valid one cycle after addr
  logic [DATA_W-1:0] rdata;

  // side that issues the access
  modport requester (
    output addr,
    output wdata,
    output wren,
    input  rdata
  );

  // side that holds the storage
  modport responder (
    input  addr,
    input  wdata,
    input  wren,
    output rdata
  );

endinterface

/* mem_map_pkg.sv */
package mem_map_pkg;

  // full byte-independent word address from the core
  localparam int ADDR_W = 32;

  // region select field, address bits 18..16
  localparam int REGION_W = 3;

  // word offset inside a region, address bits 15..0
  localparam int OFFSET_W = 16;

  // unused upper address bits above the region field
  localparam int ADDR_PAD_W = ADDR_W - REGION_W - OFFSET_W;

  // region map
  // 0..3 image banks, 4..6 unmapped, 7 peripheral window
  typedef enum logic [REGION_W-1:0] {
    IMG0   = 3'd0,
    IMG1   = 3'd1,
    IMG2   = 3'd2,
    IMG3   = 3'd3,
    UNMAP4 = 3'd4,
    UNMAP5 = 3'd5,
    UNMAP6 = 3'd6,
    IO     = 3'd7
  } region_e;

  // bank side of the address, region plus word offset into a bank
  typedef struct packed {
    logic [ADDR_PAD_W-1:0] pad;
    region_e               region;
    logic [OFFSET_W-1:0]   offset;
  } ram_view_t;

  // peripheral side of the address, region plus register index
  typedef struct packed {
    logic [ADDR_PAD_W-1:0] pad;
    region_e               region;
    logic [OFFSET_W-1:0]   reg_idx;
  } io_view_t;

  // one address word, two decodes
  typedef union packed {
    ram_view_t ram_view;
    io_view_t  io_view;
  } mem_addr_u;

endpackage

/* periph_pkg.sv */
package periph_pkg;

  // led register width, low bits of the write word
  localparam int LED_W = 8;

  // register indices inside the peripheral window
  // led register, read and write
  localparam int unsigned REG_LED = 0;
  // push button, read only
  localparam int unsigned REG_BUTTON = 1;

  // flops in the button synchronizer
  localparam int SYNC_STAGES = 2;

endpackage

/* read_data_mux.sv */
module read_data_mux
  import mem_map_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic              CLK,
  input  logic              rst_n_i,
  input  region_e           region_i,
  mem_bus_if.requester      ram_bus,
  mem_bus_if.requester      io_bus,
  output logic [DATA_W-1:0] rdata_o
);

  // region of the previous access
  region_e region_q;

  // unmapped after reset, so the read word starts at zero
  always_ff @(posedge CLK or negedge rst_n_i) begin
    if (!rst_n_i) begin
      region_q <= UNMAP4;
    end else begin
      region_q <= region_i;
    end
  end

  // same edge as the block read registers
  always_comb begin
    case (region_q)
      IMG0, IMG1, IMG2, IMG3: rdata_o = ram_bus.rdata;
      IO:                     rdata_o = io_bus.rdata;
      default:                rdata_o = '0;
    endcase
  end

  // an X region would pass X data to the core
  a_region_known : assert property (
    @(posedge CLK) disable iff (!rst_n_i) !$isunknown(region_q)
  ) else $error("read_data_mux: registered region is unknown");

endmodule

/* tb_data_memory_manager.sv */
module tb_data_memory_manager
  import mem_map_pkg::*;
  import periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW = 32;
  localparam int BANKS = 4;
  localparam int NUM_OFFS = 4;
  // synchronizer depth plus read latency plus margin
  localparam int BTN_TIMEOUT = 8;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_BUTTON
  } op_e;

  // one table row
  // chk marks rows whose read word is compared
  // exp_leds is the led state once the row has been applied
  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DW-1:0]     data;
    logic              chk;
    logic [DW-1:0]     exp_rdata;
    logic [LED_W-1:0]  exp_leds;
  } entry_t;

  logic              CLK;
  logic              rst_n_i;
  logic [ADDR_W-1:0] addr_i;
  logic [DW-1:0]     wdata_i;
  logic              wren_i;
  logic              button_i;
  logic [DW-1:0]     rdata_o;
  logic [LED_W-1:0]  leds_o;

  entry_t            table_q [$];
  // expected bank contents at the tested offsets
  logic [DW-1:0]     ref_mem [BANKS][NUM_OFFS];
  int unsigned       offs [NUM_OFFS] = '{0, 3, 257, 1023};
  logic [LED_W-1:0]  led_model;
  logic [31:0]       rng_state;
  int                n_checks;
  int                n_errors;
  int                n_timeouts;

  data_memory_manager dut_i (
    .CLK      (CLK),
    .rst_n_i  (rst_n_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .wren_i   (wren_i),
    .button_i (button_i),
    .rdata_o  (rdata_o),
    .leds_o   (leds_o)
  );

  always #5 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // region in bits 18..16 and word offset in 15..0
  // upper bits stay zero
  function automatic logic [ADDR_W-1:0] make_addr(input region_e r, input int unsigned off);
    return {{(ADDR_W - REGION_W - OFFSET_W){1'b0}}, r, off[OFFSET_W-1:0]};
  endfunction

  task automatic add_entry(input op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DW-1:0] data, input logic chk,
                           input logic [DW-1:0] exp);
    entry_t e;
    e.op        = op;
    e.addr      = addr;
    e.data      = data;
    e.chk       = chk;
    e.exp_rdata = exp;
    e.exp_leds  = led_model;
    table_q.push_back(e);
  endtask

  // write whose same-cycle read word is not defined
  task automatic write_entry(input logic [ADDR_W-1:0] addr, input logic [DW-1:0] data);
    add_entry(OP_WRITE, addr, data, 1'b0, '0);
  endtask

  // write that is also a read of the same address
  task automatic checked_write_entry(input logic [ADDR_W-1:0] addr,
                                     input logic [DW-1:0] data, input logic [DW-1:0] exp);
    add_entry(OP_WRITE, addr, data, 1'b1, exp);
  endtask

  task automatic read_entry(input logic [ADDR_W-1:0] addr, input logic [DW-1:0] exp);
    add_entry(OP_READ, addr, '0, 1'b1, exp);
  endtask

  task automatic button_entry(input logic level);
    add_entry(OP_BUTTON, make_addr(IO, REG_BUTTON), {{(DW - 1){1'b0}}, level}, 1'b0, '0);
  endtask

  task automatic build_table();
    rng_state = 32'd64;
    led_model = '0;
    // led register reads zero out of reset
    read_entry(make_addr(IO, REG_LED), '0);
    // fill every bank at the same offsets
    // a bank write returns the new word in the same cycle
    for (int b = 0; b < BANKS; b++) begin
      for (int k = 0; k < NUM_OFFS; k++) begin
        rng_state = xorshift32(rng_state);
        ref_mem[b][k] = rng_state;
        checked_write_entry(make_addr(region_e'(b), offs[k]), rng_state, ref_mem[b][k]);
      end
    end
    for (int b = 0; b < BANKS; b++) begin
      for (int k = 0; k < NUM_OFFS; k++) begin
        read_entry(make_addr(region_e'(b), offs[k]), ref_mem[b][k]);
      end
    end
    // led write keeps the low byte
    // read back zero-extended
    rng_state = xorshift32(rng_state);
    led_model = rng_state[LED_W-1:0];
    write_entry(make_addr(IO, REG_LED), rng_state);
    read_entry(make_addr(IO, REG_LED), {{(DW - LED_W){1'b0}}, led_model});
    // button index is read only
    // leds must hold
    rng_state = xorshift32(rng_state);
    write_entry(make_addr(IO, REG_BUTTON), rng_state);
    read_entry(make_addr(IO, REG_LED), {{(DW - LED_W){1'b0}}, led_model});
    // press then release
    button_entry(1'b1);
    button_entry(1'b0);
    // unmapped regions 4..6 at the bank offsets
    for (int r = 4; r < 7; r++) begin
      for (int k = 0; k < NUM_OFFS; k++) begin
        rng_state = xorshift32(rng_state);
        checked_write_entry(make_addr(region_e'(r), offs[k]), rng_state, '0);
      end
      read_entry(make_addr(region_e'(r), offs[0]), '0);
      read_entry(make_addr(region_e'(r), offs[3]), '0);
    end
    // banks untouched by the unmapped writes
    for (int b = 0; b < BANKS; b++) begin
      for (int k = 0; k < NUM_OFFS; k++) begin
        read_entry(make_addr(region_e'(b), offs[k]), ref_mem[b][k]);
      end
    end
    // back-to-back write then read of the same word
    for (int b = 0; b < BANKS; b++) begin
      rng_state = xorshift32(rng_state);
      ref_mem[b][1] = rng_state;
      checked_write_entry(make_addr(region_e'(b), offs[1]), rng_state, ref_mem[b][1]);
      read_entry(make_addr(region_e'(b), offs[1]), ref_mem[b][1]);
    end
  endtask

  task automatic check_outputs(input logic chk_rdata, input logic [ADDR_W-1:0] addr,
                               input logic [DW-1:0] exp, input logic [LED_W-1:0] exp_leds);
    n_checks++;
    assert (leds_o === exp_leds) else begin
      n_errors++;
      $display("ERROR %0t ns: leds_o is %h, expected %h", $time, leds_o, exp_leds);
    end
    if (chk_rdata) begin
      n_checks++;
      assert (rdata_o === exp) else begin
        n_errors++;
        $display("ERROR %0t ns: access to %h gave %h, expected %h", $time, addr, rdata_o, exp);
      end
    end
  endtask

  // addr_i already points at the button register, so each cycle is a read
  task automatic wait_for_button(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (rdata_o !== {{(DW - 1){1'b0}}, level} && cycles < BTN_TIMEOUT);
    n_checks++;
    assert (rdata_o === {{(DW - 1){1'b0}}, level}) else begin
      n_timeouts++;
      $display("button read never returned %0d within %0d cycles", level, BTN_TIMEOUT);
    end
  endtask

  task automatic run_table();
    entry_t            e;
    logic              pend_chk;
    logic [ADDR_W-1:0] pend_addr;
    logic [DW-1:0]     pend_exp;
    logic [LED_W-1:0]  pend_leds;
    pend_chk  = 1'b0;
    pend_addr = '0;
    pend_exp  = '0;
    pend_leds = '0;
    foreach (table_q[i]) begin
      @(negedge CLK);
      // outputs of the row applied one cycle ago
      check_outputs(pend_chk, pend_addr, pend_exp, pend_leds);
      e = table_q[i];
      pend_chk  = e.chk;
      pend_addr = e.addr;
      pend_exp  = e.exp_rdata;
      pend_leds = e.exp_leds;
      addr_i  = e.addr;
      wdata_i = e.data;
      wren_i  = (e.op == OP_WRITE);
      if (e.op == OP_BUTTON) begin
        button_i = e.data[0];
        wait_for_button(e.data[0]);
      end
    end
    @(negedge CLK);
    check_outputs(pend_chk, pend_addr, pend_exp, pend_leds);
    wren_i = 1'b0;
  endtask

  initial begin
    CLK        = 1'b0;
    rst_n_i    = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    wren_i     = 1'b0;
    button_i   = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    build_table();
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst_n_i = 1'b1;
    n_checks++;
    assert (leds_o === '0) else begin
      n_errors++;
      $display("ERROR %0t ns: leds_o is %h after reset, expected 0", $time, leds_o);
    end
    run_table();
    $display("checks %0d, value errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
